// File: mips_exec_pkg.sv
package mips_exec_pkg;

    // one value per ALU operation; immediate and variable forms share a value.
    typedef enum logic [5:0] {
        OP_ADD    = 6'd0,
        OP_SUB    = 6'd1,
        OP_AND    = 6'd2,
        OP_OR     = 6'd3,
        OP_XOR    = 6'd4,
        OP_SLL    = 6'd5,
        OP_SRL    = 6'd6,
        OP_SRA    = 6'd7,
        OP_SLT    = 6'd8,
        OP_SLTU   = 6'd9,
        OP_LUI    = 6'd10,
        OP_MULT   = 6'd11,
        OP_MULTU  = 6'd12,
        OP_DIV    = 6'd13,
        OP_DIVU   = 6'd14,
        OP_MFHI   = 6'd15,
        OP_MFLO   = 6'd16,
        OP_MTHI   = 6'd17,
        OP_MTLO   = 6'd18,
        OP_CMP_EQ = 6'd19, // a against b, signed.
        OP_CMP_Z  = 6'd20  // a against zero.
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sa;
    } exec_op_t;

    typedef struct packed {
        logic [31:0] result;
        logic        zero;
        logic        positive;
        logic        negative;
    } exec_res_t;

    // primary opcode field, instr[31:26].
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_REGIMM  = 6'h01;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_BLEZ    = 6'h06;
    localparam logic [5:0] OPC_BGTZ    = 6'h07;
    localparam logic [5:0] OPC_ADDI    = 6'h08;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LB      = 6'h20;
    localparam logic [5:0] OPC_LH      = 6'h21;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_LBU     = 6'h24;
    localparam logic [5:0] OPC_LHU     = 6'h25;
    localparam logic [5:0] OPC_SB      = 6'h28;
    localparam logic [5:0] OPC_SH      = 6'h29;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // funct field under SPECIAL, instr[5:0].
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    // rt field under REGIMM.
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    localparam int DIV_STEPS = 32; // one quotient bit per step.

endpackage

// File: instr_decode.sv
`timescale 1ns/1ps

module instr_decode import mips_exec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    output logic        push,
    output exec_op_t    entry,
    output logic        illegal
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rt_f;
    logic [4:0]  shamt;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    exec_op_t    dec;
    logic        legal;

    assign opcode   = instr[31:26];
    assign rt_f     = instr[20:16];
    assign shamt    = instr[10:6];
    assign funct    = instr[5:0];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        dec.op = OP_ADD;
        dec.a  = rs_val;
        dec.b  = rt_val;
        dec.sa = shamt;
        legal  = 1'b1;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADD, FN_ADDU: dec.op = OP_ADD; // no overflow trap.
                    FN_SUBU:         dec.op = OP_SUB;
                    FN_AND:          dec.op = OP_AND;
                    FN_OR:           dec.op = OP_OR;
                    FN_XOR:          dec.op = OP_XOR;
                    FN_SLT:          dec.op = OP_SLT;
                    FN_SLTU:         dec.op = OP_SLTU;
                    FN_SLL:          dec.op = OP_SLL;
                    FN_SRL:          dec.op = OP_SRL;
                    FN_SRA:          dec.op = OP_SRA;
                    FN_SLLV: begin
                        dec.op = OP_SLL;
                        dec.sa = rs_val[4:0];
                    end
                    FN_SRLV: begin
                        dec.op = OP_SRL;
                        dec.sa = rs_val[4:0];
                    end
                    FN_SRAV: begin
                        dec.op = OP_SRA;
                        dec.sa = rs_val[4:0];
                    end
                    FN_MULT:         dec.op = OP_MULT;
                    FN_MULTU:        dec.op = OP_MULTU;
                    FN_DIV:          dec.op = OP_DIV;
                    FN_DIVU:         dec.op = OP_DIVU;
                    FN_MFHI:         dec.op = OP_MFHI;
                    FN_MFLO:         dec.op = OP_MFLO;
                    FN_MTHI:         dec.op = OP_MTHI;
                    FN_MTLO:         dec.op = OP_MTLO;
                    default:         legal = 1'b0;
                endcase
            end
            OPC_REGIMM: begin
                dec.op = OP_CMP_Z;
                dec.b  = '0;
                legal  = (rt_f == RT_BLTZ) || (rt_f == RT_BGEZ); // no link forms.
            end
            OPC_BEQ, OPC_BNE: dec.op = OP_CMP_EQ;
            OPC_BLEZ, OPC_BGTZ: begin
                dec.op = OP_CMP_Z;
                dec.b  = '0;
            end
            OPC_ADDI, OPC_ADDIU: begin
                dec.op = OP_ADD;
                dec.b  = imm_sext;
            end
            OPC_SLTI: begin
                dec.op = OP_SLT;
                dec.b  = imm_sext;
            end
            OPC_SLTIU: begin
                dec.op = OP_SLTU;
                dec.b  = imm_sext; // sign-extended, then compared unsigned.
            end
            OPC_ANDI: begin
                dec.op = OP_AND;
                dec.b  = imm_zext;
            end
            OPC_ORI: begin
                dec.op = OP_OR;
                dec.b  = imm_zext;
            end
            OPC_XORI: begin
                dec.op = OP_XOR;
                dec.b  = imm_zext;
            end
            OPC_LUI: begin
                dec.op = OP_LUI;
                dec.b  = imm_zext;
            end
            OPC_LB, OPC_LBU, OPC_LH, OPC_LHU, OPC_LW, OPC_SB, OPC_SH, OPC_SW: begin
                dec.op = OP_ADD; // effective address only.
                dec.b  = imm_sext;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            push    <= instr_valid && legal;
            illegal <= instr_valid && !legal;
        end
        entry <= dec;
    end

endmodule

// File: exec_queue.sv
`timescale 1ns/1ps

module exec_queue import mips_exec_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  exec_op_t push_entry,
    input  logic     pop,
    output exec_op_t head,
    output logic     empty,
    output logic     full
);

    localparam int ADDR_W = $clog2(QUEUE_DEPTH);

    exec_op_t        mem [QUEUE_DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            do_push;
    logic            do_pop;

    // extra pointer bit tells full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // a pop frees the slot this cycle.

    assign head = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_entry;
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import mips_exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  exec_op_t  op_in,
    input  logic      empty,
    output logic      pop,
    output logic      result_valid,
    output exec_res_t res
);

    localparam int CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        DIVIDING,
        DIV_DONE
    } state_e;

    state_e      state;
    logic [31:0] hi;
    logic [31:0] lo;
    exec_res_t   nxt_res;
    logic        has_result;
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic        is_sdiv;

    logic [CNT_W-1:0] div_cnt;
    logic [31:0]      div_rem;
    logic [31:0]      div_quo;
    logic [31:0]      div_dvs;
    logic             div_neg_q;
    logic             div_neg_r;
    logic             div_zero;
    logic [32:0]      div_shift;
    logic [32:0]      div_trial;

    assign pop = (state == IDLE) && !empty;

    assign prod_s = $signed(op_in.a) * $signed(op_in.b);
    assign prod_u = 64'(op_in.a) * 64'(op_in.b);

    // divide works on magnitudes; signs are restored in DIV_DONE.
    assign is_sdiv = (op_in.op == OP_DIV);
    assign a_mag   = (is_sdiv && op_in.a[31]) ? -op_in.a : op_in.a;
    assign b_mag   = (is_sdiv && op_in.b[31]) ? -op_in.b : op_in.b;

    // one restoring step.
    assign div_shift = {div_rem, div_quo[31]};
    assign div_trial = div_shift - {1'b0, div_dvs};

    always_comb begin
        nxt_res    = '0;
        has_result = 1'b1;
        case (op_in.op)
            OP_ADD:   nxt_res.result = op_in.a + op_in.b;
            OP_SUB:   nxt_res.result = op_in.a - op_in.b;
            OP_AND:   nxt_res.result = op_in.a & op_in.b;
            OP_OR:    nxt_res.result = op_in.a | op_in.b;
            OP_XOR:   nxt_res.result = op_in.a ^ op_in.b;
            OP_SLL:   nxt_res.result = op_in.b << op_in.sa;
            OP_SRL:   nxt_res.result = op_in.b >> op_in.sa;
            OP_SRA:   nxt_res.result = $signed(op_in.b) >>> op_in.sa;
            OP_SLT:   nxt_res.result = {31'b0, $signed(op_in.a) < $signed(op_in.b)};
            OP_SLTU:  nxt_res.result = {31'b0, op_in.a < op_in.b};
            OP_LUI:   nxt_res.result = {op_in.b[15:0], 16'h0000};
            OP_MFHI:  nxt_res.result = hi;
            OP_MFLO:  nxt_res.result = lo;
            OP_CMP_EQ: begin
                nxt_res.zero     = (op_in.a == op_in.b);
                nxt_res.positive = $signed(op_in.a) > $signed(op_in.b);
                nxt_res.negative = $signed(op_in.a) < $signed(op_in.b);
            end
            OP_CMP_Z: begin
                nxt_res.zero     = (op_in.a == 32'h0);
                nxt_res.positive = $signed(op_in.a) > 0;
                nxt_res.negative = op_in.a[31];
            end
            default:  has_result = 1'b0; // hi/lo writers.
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            result_valid <= 1'b0;
            res          <= '0;
            hi           <= '0;
            lo           <= '0;
            div_cnt      <= '0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop) begin
                        result_valid <= has_result;
                        if (has_result) begin
                            res <= nxt_res;
                        end
                        case (op_in.op)
                            OP_MULT: begin
                                hi <= prod_s[63:32];
                                lo <= prod_s[31:0];
                            end
                            OP_MULTU: begin
                                hi <= prod_u[63:32];
                                lo <= prod_u[31:0];
                            end
                            OP_MTHI: hi <= op_in.a;
                            OP_MTLO: lo <= op_in.a;
                            OP_DIV, OP_DIVU: begin
                                state   <= DIVIDING;
                                div_cnt <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                DIVIDING: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == CNT_W'(DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    // remainder follows the dividend's sign.
                    hi    <= div_neg_r ? -div_rem : div_rem;
                    lo    <= div_zero ? '1 : (div_neg_q ? -div_quo : div_quo);
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // divider datapath.
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            div_rem   <= '0;
            div_quo   <= a_mag;
            div_dvs   <= b_mag;
            div_neg_q <= is_sdiv && (op_in.a[31] ^ op_in.b[31]);
            div_neg_r <= is_sdiv && op_in.a[31];
            div_zero  <= (op_in.b == 32'h0);
        end else if (state == DIVIDING) begin
            if (!div_trial[32]) begin
                div_rem <= div_trial[31:0];
                div_quo <= {div_quo[30:0], 1'b1};
            end else begin
                div_rem <= div_shift[31:0];
                div_quo <= {div_quo[30:0], 1'b0};
            end
        end
    end

endmodule

// File: mips_exec_top.sv
`timescale 1ns/1ps

module mips_exec_top import mips_exec_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    output logic        busy,
    output logic        illegal,
    output logic        result_valid,
    output exec_res_t   res
);

    logic     push;
    exec_op_t dec_entry;
    logic     pop;
    exec_op_t q_head;
    logic     q_empty;

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .push        (push),
        .entry       (dec_entry),
        .illegal     (illegal)
    );

    exec_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_entry (dec_entry),
        .pop        (pop),
        .head       (q_head),
        .empty      (q_empty),
        .full       (busy)    // stimulus holds off while full.
    );

    alu u_alu (
        .clk          (clk),
        .reset        (reset),
        .op_in        (q_head),
        .empty        (q_empty),
        .pop          (pop),
        .result_valid (result_valid),
        .res          (res)
    );

endmodule

// File: mips_exec_checker.sv
`timescale 1ns/1ps

module mips_exec_checker import mips_exec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    input  logic        use_model,
    input  exec_res_t   exp_res,
    input  logic        exp_has,
    input  logic        exp_illegal,
    input  logic        final_check,
    input  logic        busy,
    input  logic        illegal,
    input  logic        result_valid,
    input  exec_res_t   res,
    output int          errors,
    output int          checks,
    output int          outstanding
);

    exec_res_t exp_q[$];
    int        illegal_due;
    exec_res_t want;
    logic      busy_seen;

    // reference for the R-type ALU subset used by the random phase.
    function automatic exec_res_t model(input logic [31:0] ins, input logic [31:0] a,
                                        input logic [31:0] b);
        exec_res_t r;
        logic [4:0] sa;
        r  = '0;
        sa = ins[10:6];
        case (ins[5:0])
            FN_ADDU: r.result = a + b;
            FN_SUBU: r.result = a - b;
            FN_AND:  r.result = a & b;
            FN_OR:   r.result = a | b;
            FN_XOR:  r.result = a ^ b;
            FN_SLT:  r.result = {31'b0, $signed(a) < $signed(b)};
            FN_SLTU: r.result = {31'b0, a < b};
            FN_SLL:  r.result = b << sa;
            FN_SRL:  r.result = b >> sa;
            FN_SRA:  r.result = $signed(b) >>> sa;
            FN_SLLV: r.result = b << a[4:0];
            FN_SRLV: r.result = b >> a[4:0];
            FN_SRAV: r.result = $signed(b) >>> a[4:0];
            default: r.result = 32'hdead_beef; // not in the random mix.
        endcase
        return r;
    endfunction

    initial begin
        errors      = 0;
        checks      = 0;
        illegal_due = 0;
        busy_seen   = 1'b0;
    end

    assign outstanding = exp_q.size() + illegal_due;

    always @(posedge clk) begin
        if (!reset) begin
            if (busy) begin
                busy_seen = 1'b1;
            end
            if (instr_valid) begin
                if (exp_illegal) begin
                    illegal_due = illegal_due + 1;
                end else if (use_model) begin
                    exp_q.push_back(model(instr, rs_val, rt_val));
                end else if (exp_has) begin
                    exp_q.push_back(exp_res);
                end
            end
            if (illegal) begin
                if (illegal_due == 0) begin
                    $display("error at %0t: illegal pulse with no illegal instruction sent", $time);
                    errors = errors + 1;
                end else begin
                    illegal_due = illegal_due - 1;
                end
            end
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: result arrived with nothing expected", $time);
                    errors = errors + 1;
                end else begin
                    want   = exp_q.pop_front();
                    checks = checks + 1;
                    if (res.result !== want.result) begin
                        $display("mismatch at %0t: res.result got %h expected %h",
                                 $time, res.result, want.result);
                        errors = errors + 1;
                    end
                    if ({res.zero, res.positive, res.negative} !==
                        {want.zero, want.positive, want.negative}) begin
                        $display("mismatch at %0t: res flags got %b expected %b", $time,
                                 {res.zero, res.positive, res.negative},
                                 {want.zero, want.positive, want.negative});
                        errors = errors + 1;
                    end
                end
            end
            if (final_check && (exp_q.size() != 0 || illegal_due != 0)) begin
                $display("error: %0d results and %0d illegal pulses never arrived",
                         exp_q.size(), illegal_due);
                errors = errors + 1;
            end
            if (final_check && !busy_seen) begin
                $display("error: busy never went high while the divide held the queue");
                errors = errors + 1;
            end
        end
    end

endmodule

// File: mips_exec_properties.sv
`timescale 1ns/1ps

module mips_exec_properties import mips_exec_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      instr_valid,
    input logic      busy,
    input logic      result_valid,
    input exec_res_t res
);

    // the issuer must hold off while the queue is full.
    no_issue_when_busy: assert property (@(posedge clk) disable iff (reset)
        !(instr_valid && busy))
        else $error("instr_valid asserted while busy");

    flags_one_hot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({res.zero, res.positive, res.negative}))
        else $error("more than one compare flag set");

    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !result_valid)
        else $error("result_valid asserted during reset");

endmodule

bind mips_exec_top mips_exec_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .busy         (busy),
    .result_valid (result_valid),
    .res          (res)
);

// File: tb_mips_exec.sv
`timescale 1ns/1ps

module tb_mips_exec import mips_exec_pkg::*; ;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs;
        logic [31:0] rt;
        exec_res_t   exp;
        logic        has_res;
        logic        illegal;
    } stim_row_t;

    localparam int RANDOM_COUNT = 200;
    localparam int DRAIN_CYCLES = 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic        busy;
    logic        illegal;
    logic        result_valid;
    exec_res_t   res;
    logic        use_model;
    exec_res_t   exp_res;
    logic        exp_has;
    logic        exp_illegal;
    logic        final_check;
    logic        table_ready = 1'b0;
    int          errors;
    int          checks;
    int          outstanding;
    int          seed_val;
    stim_row_t   rows[$];
    logic [5:0]  rand_functs [13] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT,
        FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

    always #4 clk = ~clk;

    mips_exec_top #(.QUEUE_DEPTH(4)) uut (.*);

    mips_exec_checker u_checker (.*);

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] sh);
        return {OPC_SPECIAL, 15'd0, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] opc, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {opc, 5'd0, rt, imm};
    endfunction

    // flags are zero, positive, negative.
    task automatic add_row(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] r, input logic [2:0] f, input logic has,
                           input logic ill);
        rows.push_back({ins, a, b, r, f, has, ill});
    endtask

    task automatic build_table();
        add_row(rtype(FN_ADDU, 0), 32'd5, 32'd7, 32'h0000000c, 3'b000, 1, 0);
        add_row(itype(OPC_ADDIU, 0, 16'hfffe), 32'd10, 0, 32'h00000008, 3'b000, 1, 0);
        add_row(rtype(FN_SUBU, 0), 32'd3, 32'd5, 32'hfffffffe, 3'b000, 1, 0);
        add_row(itype(OPC_ANDI, 0, 16'hff0f), 32'h12345678, 0, 32'h00005608, 3'b000, 1, 0);
        add_row(rtype(FN_OR, 0), 32'h0f00, 32'h00f0, 32'h00000ff0, 3'b000, 1, 0);
        add_row(itype(OPC_ORI, 0, 16'h8001), 32'h0, 0, 32'h00008001, 3'b000, 1, 0);
        add_row(rtype(FN_XOR, 0), 32'haaaa5555, '1, 32'h5555aaaa, 3'b000, 1, 0);
        add_row(itype(OPC_XORI, 0, 16'h8000), 32'h0, 0, 32'h00008000, 3'b000, 1, 0);
        add_row(itype(OPC_LUI, 0, 16'h1234), 32'h0, 0, 32'h12340000, 3'b000, 1, 0);
        add_row(rtype(FN_SLL, 4), 0, 32'h0000000f, 32'h000000f0, 3'b000, 1, 0);
        add_row(rtype(FN_SLLV, 0), 32'h24, 32'h1, 32'h00000010, 3'b000, 1, 0);
        add_row(rtype(FN_SRA, 8), 0, 32'h80000000, 32'hff800000, 3'b000, 1, 0);
        add_row(rtype(FN_SRAV, 0), 32'h3f, 32'h80000000, 32'hffffffff, 3'b000, 1, 0);
        add_row(rtype(FN_SRLV, 0), 32'h21, 32'h80000000, 32'h40000000, 3'b000, 1, 0);
        add_row(rtype(FN_SLT, 0), 32'h80000000, 32'h1, 32'h00000001, 3'b000, 1, 0);
        add_row(rtype(FN_SLTU, 0), 32'h80000000, 32'h1, 32'h00000000, 3'b000, 1, 0);
        add_row(itype(OPC_SLTIU, 0, 16'hffff), 32'h1, 0, 32'h00000001, 3'b000, 1, 0);
        add_row(rtype(FN_MULT, 0), 32'hfffffffe, 32'd3, 0, 3'b000, 0, 0);
        add_row(rtype(FN_MFHI, 0), 0, 0, 32'hffffffff, 3'b000, 1, 0);
        add_row(rtype(FN_MFLO, 0), 0, 0, 32'hfffffffa, 3'b000, 1, 0);
        add_row(rtype(FN_MULTU, 0), 32'hffffffff, 32'd2, 0, 3'b000, 0, 0);
        add_row(rtype(FN_MFHI, 0), 0, 0, 32'h00000001, 3'b000, 1, 0);
        add_row(rtype(FN_MFLO, 0), 0, 0, 32'hfffffffe, 3'b000, 1, 0);
        add_row(rtype(FN_MTHI, 0), 32'hcafe0001, 0, 0, 3'b000, 0, 0);
        add_row(rtype(FN_MTLO, 0), 32'h0000beef, 0, 0, 3'b000, 0, 0);
        add_row(rtype(FN_MFHI, 0), 0, 0, 32'hcafe0001, 3'b000, 1, 0);
        add_row(rtype(FN_MFLO, 0), 0, 0, 32'h0000beef, 3'b000, 1, 0);
        // the ADDUs pile up behind the divide until busy rises.
        add_row(rtype(FN_DIV, 0), 32'hfffffff9, 32'd2, 0, 3'b000, 0, 0);
        for (int i = 1; i <= 5; i++) begin
            add_row(rtype(FN_ADDU, 0), i, i, 2 * i, 3'b000, 1, 0);
        end
        add_row(rtype(FN_MFHI, 0), 0, 0, 32'hffffffff, 3'b000, 1, 0);
        add_row(rtype(FN_MFLO, 0), 0, 0, 32'hfffffffd, 3'b000, 1, 0);
        add_row(rtype(FN_DIVU, 0), 32'h12345678, 32'd0, 0, 3'b000, 0, 0);
        add_row(rtype(FN_MFHI, 0), 0, 0, 32'h12345678, 3'b000, 1, 0);
        add_row(rtype(FN_MFLO, 0), 0, 0, 32'hffffffff, 3'b000, 1, 0);
        add_row(itype(OPC_BEQ, 0, 16'h0010), 32'd5, 32'd5, 0, 3'b100, 1, 0);
        add_row(itype(OPC_BNE, 0, 16'h0010), 32'd3, 32'd9, 0, 3'b001, 1, 0);
        add_row(itype(OPC_REGIMM, RT_BGEZ, 16'h0010), 32'd7, 0, 0, 3'b010, 1, 0);
        add_row(itype(OPC_BGTZ, 0, 16'h0010), 32'd0, 0, 0, 3'b100, 1, 0);
        add_row(itype(OPC_BLEZ, 0, 16'h0010), 32'hffffffff, 0, 0, 3'b001, 1, 0);
        add_row(itype(OPC_REGIMM, RT_BLTZ, 16'h0010), 32'h80000000, 0, 0, 3'b001, 1, 0);
        add_row(itype(OPC_LW, 0, 16'hfffc), 32'h1000, 0, 32'h00000ffc, 3'b000, 1, 0);
        add_row(itype(OPC_SB, 0, 16'h0010), 32'h2000, 0, 32'h00002010, 3'b000, 1, 0);
        add_row(32'h08000000, 0, 0, 0, 3'b000, 0, 1); // J is not supported.
    endtask

    // wait until the queue has room, then strobe for one cycle.
    task automatic issue(input stim_row_t row, input logic model);
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= row.instr;
        rs_val      <= row.rs;
        rt_val      <= row.rt;
        use_model   <= model;
        exp_res     <= row.exp;
        exp_has     <= row.has_res;
        exp_illegal <= row.illegal;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(posedge clk); // the decoded entry reaches the queue here.
    endtask

    initial begin
        stim_row_t r;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        use_model   = 1'b0;
        exp_res     = '0;
        exp_has     = 1'b0;
        exp_illegal = 1'b0;
        final_check = 1'b0;
        seed_val    = $urandom(32'h5d3e);
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            issue(rows[i], 1'b0);
        end
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            r = '0;
            r.instr   = rtype(rand_functs[$urandom % 13], 5'($urandom));
            r.rs      = $urandom;
            r.rt      = $urandom;
            r.has_res = 1'b1;
            issue(r, 1'b1);
        end
        repeat (3) @(posedge clk);
        for (int w = 0; w < DRAIN_CYCLES && outstanding != 0; w++) begin
            @(posedge clk);
        end
        @(posedge clk);
        final_check <= 1'b1;
        @(posedge clk);
        final_check <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d, results checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(longint'(rows.size() + RANDOM_COUNT) * 40 * 8);
        $display("timeout: the run did not finish in the allowed time");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: mips_exec.f
mips_exec_pkg.sv
instr_decode.sv
exec_queue.sv
alu.sv
mips_exec_top.sv
mips_exec_checker.sv
mips_exec_properties.sv
tb_mips_exec.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_exec \
    -f mips_exec.f -o sim_mips_exec
./obj_dir/sim_mips_exec > sim.log 2>&1 || true
cat sim.log
grep -q "^Done: no errors$" sim.log
